// ==== design/mbox_pkg.sv ====
// Types and constants shared by the whole mailbox.
// Registers are one data word wide and word aligned, and byte strobes are not supported.
// The response codes follow the AXI4-Lite encoding. EXOKAY and DECERR are never produced.

package mbox_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // --------------------
  // register map, index i at byte offset 4*i
  // --------------------
  localparam int unsigned NUM_REGS = 10;

  typedef enum logic [3:0] {
    MBOXW  = 4'd0,  // push word to the other side
    MBOXR  = 4'd1,  // pop word from the other side
    STATUS = 4'd2,  // fifo flags and threshold compare, read only
    ERROR  = 4'd3,  // read to clear
    WIRQT  = 4'd4,  // write usage threshold
    RIRQT  = 4'd5,  // read usage threshold
    IRQS   = 4'd6,  // sticky, write 1 to clear
    IRQEN  = 4'd7,
    IRQP   = 4'd8,  // irqs & irqen, read only
    CTRL   = 4'd9   // flush strobes, reads as 0
  } reg_e;

  // response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // read channel payload
  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_beat_t;

  // fixed read patterns
  localparam data_t MBOXW_READ_DATA = 32'hFEEDC0DE;  // MBOXW is write only
  localparam data_t EMPTY_READ_DATA = 32'hFEEDDEAD;  // MBOXR read while empty

endpackage

// ==== design/mbox_fifo_if.sv ====
// Joins one mailbox FIFO to the port that pushes and the port that pops.
// usage is one bit wider than the count. Its top bit is the full flag.

interface mbox_fifo_if #(
  parameter int unsigned MailboxDepth = 8
);
  localparam int unsigned UsageWidth = $clog2(MailboxDepth) + 1;

  mbox_pkg::data_t         wdata;   // from writer
  logic                    push;
  logic                    wflush;
  logic                    pop;     // from reader
  logic                    rflush;
  logic                    full;    // from fifo
  logic                    empty;
  mbox_pkg::data_t         rdata;
  logic [UsageWidth-1:0]   usage;

  modport fifo   (input wdata, push, wflush, pop, rflush, output full, empty, rdata, usage);
  modport writer (output wdata, push, wflush, input full, usage);
  modport reader (output pop, rflush, input empty, rdata, usage);

endinterface

// ==== design/mbox_fifo.sv ====
// Mailbox FIFO without fall-through. A pushed word shows up one cycle later.
// Push when full and pop when empty are ignored.
// A flush from either side clears the FIFO at the clock edge and drops a push in the same cycle.

module mbox_fifo #(
  parameter int unsigned MailboxDepth = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  mbox_fifo_if.fifo  fifo_if
);
  localparam int unsigned PtrWidth = $clog2(MailboxDepth);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;   // holds 0..depth

  mbox_pkg::data_t mem_q [MailboxDepth];  // payload, no reset
  ptr_t            wr_ptr_q, rd_ptr_q;
  cnt_t            count_q;
  logic            flush;
  logic            do_push, do_pop;

  // wrap at depth, which need not be a power of two
  function automatic ptr_t inc_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(MailboxDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign flush         = fifo_if.wflush | fifo_if.rflush;
  assign fifo_if.full  = (count_q == cnt_t'(MailboxDepth));
  assign fifo_if.empty = (count_q == '0);
  assign fifo_if.rdata = mem_q[rd_ptr_q];                       // head word
  assign fifo_if.usage = {fifo_if.full, count_q[PtrWidth-1:0]};

  assign do_push = fifo_if.push & ~fifo_if.full;
  assign do_pop  = fifo_if.pop & ~fifo_if.empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= fifo_if.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= inc_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= inc_ptr(rd_ptr_q);
      // count moves only on push xor pop
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== design/mbox_reg_decode.sv ====
// Address decoder for one port. It gives the register index relative to BaseAddr.
// Addresses below the base wrap to large offsets and miss.
// On a miss reg_o has no meaning, and the port answers with SLVERR.

module mbox_reg_decode #(
  parameter mbox_pkg::addr_t BaseAddr = '0
) (
  input  mbox_pkg::addr_t addr_i,
  output mbox_pkg::reg_e  reg_o,
  output logic            hit_o
);
  mbox_pkg::addr_t offset;
  logic            aligned;
  logic            in_range;

  assign offset = addr_i - BaseAddr;

  // word aligned only
  assign aligned  = (offset[1:0] == 2'b00);
  // last register ends at 4*NUM_REGS
  assign in_range = (offset < mbox_pkg::addr_t'(4 * mbox_pkg::NUM_REGS));

  assign reg_o = mbox_pkg::reg_e'(offset[5:2]);  // word index
  assign hit_o = aligned & in_range;

endmodule

// ==== design/mbox_resp_reg.sv ====
// One-entry response holding register with valid/ready on both sides.
// It takes a new entry in the same cycle as the old one is taken, so with ready
// held high one response per cycle gets through.
// The payload stays stable while out_valid is high and out_ready is low.

module mbox_resp_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);
  logic     valid_q;
  payload_t data_q;
  logic     load;

  // empty, or the held entry leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;  // drained
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) data_q <= in_data_i;
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== design/mbox_port_ctrl.sv ====
// Register block of one mailbox port. It holds the registers, the bus handshakes,
// the FIFO control and the interrupt.
// A write needs aw and w valid together, and all writes take the full word.
// Responses leave one cycle after the handshake, through the holding registers.
// irq_o is a registered level that follows IRQP one cycle later.

module mbox_port_ctrl #(
  parameter int unsigned     MailboxDepth = 8,
  parameter mbox_pkg::addr_t BaseAddr     = '0
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // write address and data
  input  logic            aw_valid_i,
  input  mbox_pkg::addr_t aw_addr_i,
  output logic            aw_ready_o,
  input  logic            w_valid_i,
  input  mbox_pkg::data_t w_data_i,
  output logic            w_ready_o,
  // write response
  output logic            b_valid_o,
  output mbox_pkg::resp_e b_resp_o,
  input  logic            b_ready_i,
  // read address
  input  logic            ar_valid_i,
  input  mbox_pkg::addr_t ar_addr_i,
  output logic            ar_ready_o,
  // read data
  output logic            r_valid_o,
  output mbox_pkg::data_t r_data_o,
  output mbox_pkg::resp_e r_resp_o,
  input  logic            r_ready_i,
  output logic            irq_o,
  mbox_fifo_if.writer     wr_if,    // words to the other side
  mbox_fifo_if.reader     rd_if     // words from the other side
);
  localparam int unsigned UsageWidth = $clog2(MailboxDepth) + 1;

  typedef logic [UsageWidth-1:0] usage_t;

  mbox_pkg::reg_e    w_reg, r_reg;
  logic              w_hit, r_hit;
  logic              b_in_ready, r_in_ready;
  logic              wr_go, rd_go;            // handshake this cycle
  mbox_pkg::resp_e   b_resp;
  mbox_pkg::r_beat_t r_beat, r_out;

  logic [1:0] error_q, error_d;   // bit 0 read empty, bit 1 write full
  usage_t     wirqt_q, wirqt_d;
  usage_t     rirqt_q, rirqt_d;
  logic [2:0] irqs_q, irqs_d;     // 0 write thr, 1 read thr, 2 error
  logic [2:0] irqen_q, irqen_d;
  logic [3:0] status;
  logic [2:0] irqp;
  logic [1:0] err_set;
  usage_t     thr_wdata;

  // --------------------
  // decode
  // --------------------
  mbox_reg_decode #(.BaseAddr(BaseAddr)) w_decode_i (
    .addr_i (aw_addr_i),
    .reg_o  (w_reg),
    .hit_o  (w_hit)
  );

  mbox_reg_decode #(.BaseAddr(BaseAddr)) r_decode_i (
    .addr_i (ar_addr_i),
    .reg_o  (r_reg),
    .hit_o  (r_hit)
  );

  // handshakes, ready only toward a pending request
  assign wr_go      = aw_valid_i & w_valid_i & b_in_ready;
  assign rd_go      = ar_valid_i & r_in_ready;
  assign aw_ready_o = wr_go;
  assign w_ready_o  = wr_go;   // aw and w taken together
  assign ar_ready_o = rd_go;

  assign status = {rd_if.usage > rirqt_q,
                   wr_if.usage > wirqt_q,
                   wr_if.full,
                   rd_if.empty};
  assign irqp   = irqs_q & irqen_q;

  assign wr_if.wdata = w_data_i;
  // threshold clamped to depth-1 so a full fifo still triggers
  assign thr_wdata = (w_data_i >= mbox_pkg::data_t'(MailboxDepth)) ?
                     usage_t'(MailboxDepth - 1) : w_data_i[UsageWidth-1:0];

  // --------------------
  // execute
  // --------------------
  always_comb begin
    r_beat       = '{data: '0, resp: mbox_pkg::SLVERR};  // unmapped default
    b_resp       = mbox_pkg::SLVERR;
    error_d      = error_q;
    wirqt_d      = wirqt_q;
    rirqt_d      = rirqt_q;
    irqs_d       = irqs_q;
    irqen_d      = irqen_q;
    err_set      = 2'b00;
    wr_if.push   = 1'b0;
    wr_if.wflush = 1'b0;
    rd_if.pop    = 1'b0;
    rd_if.rflush = 1'b0;

    // read side
    if (r_hit) begin
      r_beat.resp = mbox_pkg::OKAY;
      unique case (r_reg)
        mbox_pkg::MBOXW:  r_beat.data = mbox_pkg::MBOXW_READ_DATA;
        mbox_pkg::MBOXR: begin
          if (!rd_if.empty) begin
            r_beat.data = rd_if.rdata;
            rd_if.pop   = rd_go;
          end else begin
            r_beat = '{data: mbox_pkg::EMPTY_READ_DATA, resp: mbox_pkg::SLVERR};
            err_set[0] = rd_go;
          end
        end
        mbox_pkg::STATUS: r_beat.data = mbox_pkg::data_t'(status);
        mbox_pkg::ERROR: begin
          r_beat.data = mbox_pkg::data_t'(error_q);
          if (rd_go) error_d = 2'b00;    // read to clear
        end
        mbox_pkg::WIRQT:  r_beat.data = mbox_pkg::data_t'(wirqt_q);
        mbox_pkg::RIRQT:  r_beat.data = mbox_pkg::data_t'(rirqt_q);
        mbox_pkg::IRQS:   r_beat.data = mbox_pkg::data_t'(irqs_q);
        mbox_pkg::IRQEN:  r_beat.data = mbox_pkg::data_t'(irqen_q);
        mbox_pkg::IRQP:   r_beat.data = mbox_pkg::data_t'(irqp);
        default: ;                       // CTRL reads 0
      endcase
    end

    // write side
    if (w_hit) begin
      b_resp = mbox_pkg::OKAY;
      unique case (w_reg)
        mbox_pkg::MBOXW: begin
          if (!wr_if.full) begin
            wr_if.push = wr_go;
          end else begin
            b_resp     = mbox_pkg::SLVERR;
            err_set[1] = wr_go;
          end
        end
        mbox_pkg::WIRQT: if (wr_go) wirqt_d = thr_wdata;
        mbox_pkg::RIRQT: if (wr_go) rirqt_d = thr_wdata;
        mbox_pkg::IRQS:  if (wr_go) irqs_d = irqs_q & ~w_data_i[2:0];  // w1c
        mbox_pkg::IRQEN: if (wr_go) irqen_d = w_data_i[2:0];
        mbox_pkg::CTRL: begin
          wr_if.wflush = wr_go & w_data_i[0];  // one cycle strobes
          rd_if.rflush = wr_go & w_data_i[1];
        end
        default: ;                       // read only, OKAY and no effect
      endcase
    end

    // sets come after clears so a new event wins
    error_d   = error_d | err_set;
    irqs_d[0] = irqs_d[0] | status[2];
    irqs_d[1] = irqs_d[1] | status[3];
    irqs_d[2] = irqs_d[2] | (|err_set);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
      irq_o   <= 1'b0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
      irq_o   <= |irqp;   // level, active high
    end
  end

  // --------------------
  // result
  // --------------------
  mbox_resp_reg #(.payload_t(mbox_pkg::resp_e)) b_resp_reg_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (aw_valid_i & w_valid_i),
    .in_ready_o  (b_in_ready),
    .in_data_i   (b_resp),
    .out_valid_o (b_valid_o),
    .out_ready_i (b_ready_i),
    .out_data_o  (b_resp_o)
  );

  mbox_resp_reg #(.payload_t(mbox_pkg::r_beat_t)) r_resp_reg_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (ar_valid_i),
    .in_ready_o  (r_in_ready),
    .in_data_i   (r_beat),
    .out_valid_o (r_valid_o),
    .out_ready_i (r_ready_i),
    .out_data_o  (r_out)
  );

  assign r_data_o = r_out.data;
  assign r_resp_o = r_out.resp;

endmodule

// ==== design/axi_lite_mbox.sv ====
// Two-port AXI4-Lite mailbox top level. Index 0 and 1 of every channel array select the port.
// Each port pushes into its own FIFO and pops from the FIFO that the other port fills.
// The port base addresses are fixed by parameters, and the two register windows must not overlap.

module axi_lite_mbox #(
  parameter int unsigned     MailboxDepth = 8,
  parameter mbox_pkg::addr_t Port0Base    = 16'h1000,
  parameter mbox_pkg::addr_t Port1Base    = 16'h2000
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic            [1:0] aw_valid_i,
  input  mbox_pkg::addr_t [1:0] aw_addr_i,
  output logic            [1:0] aw_ready_o,
  input  logic            [1:0] w_valid_i,
  input  mbox_pkg::data_t [1:0] w_data_i,
  output logic            [1:0] w_ready_o,
  output logic            [1:0] b_valid_o,
  output mbox_pkg::resp_e [1:0] b_resp_o,
  input  logic            [1:0] b_ready_i,
  input  logic            [1:0] ar_valid_i,
  input  mbox_pkg::addr_t [1:0] ar_addr_i,
  output logic            [1:0] ar_ready_o,
  output logic            [1:0] r_valid_o,
  output mbox_pkg::data_t [1:0] r_data_o,
  output mbox_pkg::resp_e [1:0] r_resp_o,
  input  logic            [1:0] r_ready_i,
  output logic            [1:0] irq_o
);

  // --------------------
  // fifos, one per direction
  // --------------------
  mbox_fifo_if #(.MailboxDepth(MailboxDepth)) mbox_0to1_if ();
  mbox_fifo_if #(.MailboxDepth(MailboxDepth)) mbox_1to0_if ();

  mbox_fifo #(.MailboxDepth(MailboxDepth)) mbox_0to1_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .fifo_if (mbox_0to1_if)
  );

  mbox_fifo #(.MailboxDepth(MailboxDepth)) mbox_1to0_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .fifo_if (mbox_1to0_if)
  );

  // --------------------
  // ports, crossed over
  // --------------------
  mbox_port_ctrl #(
    .MailboxDepth (MailboxDepth),
    .BaseAddr     (Port0Base)
  ) port_0_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i[0]),
    .aw_addr_i  (aw_addr_i[0]),
    .aw_ready_o (aw_ready_o[0]),
    .w_valid_i  (w_valid_i[0]),
    .w_data_i   (w_data_i[0]),
    .w_ready_o  (w_ready_o[0]),
    .b_valid_o  (b_valid_o[0]),
    .b_resp_o   (b_resp_o[0]),
    .b_ready_i  (b_ready_i[0]),
    .ar_valid_i (ar_valid_i[0]),
    .ar_addr_i  (ar_addr_i[0]),
    .ar_ready_o (ar_ready_o[0]),
    .r_valid_o  (r_valid_o[0]),
    .r_data_o   (r_data_o[0]),
    .r_resp_o   (r_resp_o[0]),
    .r_ready_i  (r_ready_i[0]),
    .irq_o      (irq_o[0]),
    .wr_if      (mbox_0to1_if),   // push toward port 1
    .rd_if      (mbox_1to0_if)    // pop what port 1 sent
  );

  mbox_port_ctrl #(
    .MailboxDepth (MailboxDepth),
    .BaseAddr     (Port1Base)
  ) port_1_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i[1]),
    .aw_addr_i  (aw_addr_i[1]),
    .aw_ready_o (aw_ready_o[1]),
    .w_valid_i  (w_valid_i[1]),
    .w_data_i   (w_data_i[1]),
    .w_ready_o  (w_ready_o[1]),
    .b_valid_o  (b_valid_o[1]),
    .b_resp_o   (b_resp_o[1]),
    .b_ready_i  (b_ready_i[1]),
    .ar_valid_i (ar_valid_i[1]),
    .ar_addr_i  (ar_addr_i[1]),
    .ar_ready_o (ar_ready_o[1]),
    .r_valid_o  (r_valid_o[1]),
    .r_data_o   (r_data_o[1]),
    .r_resp_o   (r_resp_o[1]),
    .r_ready_i  (r_ready_i[1]),
    .irq_o      (irq_o[1]),
    .wr_if      (mbox_1to0_if),
    .rd_if      (mbox_0to1_if)
  );

endmodule

// ==== testbench/mbox_checker.sv ====
// Concurrent checks on the mailbox top level, bound into axi_lite_mbox.
// Watches the response channels, the aw/w ready pair and irq_o after reset.

module mbox_checker (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic            [1:0] aw_ready_o,
  input logic            [1:0] w_ready_o,
  input logic            [1:0] b_valid_o,
  input mbox_pkg::resp_e [1:0] b_resp_o,
  input logic            [1:0] b_ready_i,
  input logic            [1:0] r_valid_o,
  input mbox_pkg::data_t [1:0] r_data_o,
  input mbox_pkg::resp_e [1:0] r_resp_o,
  input logic            [1:0] r_ready_i,
  input logic            [1:0] irq_o
);

  // aw and w always taken together
  ready_pair_a: assert property (@(posedge clk_i) aw_ready_o == w_ready_o)
    else $error("aw_ready and w_ready differ");

  // level irq, registers all clear out of reset
  irq_after_reset_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> irq_o == 2'b00)
    else $error("irq_o high right after reset release");

  for (genvar p = 0; p < 2; p++) begin : g_port
    b_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      b_valid_o[p] && !b_ready_i[p] |=> b_valid_o[p] && $stable(b_resp_o[p]))
      else $error("port %0d b response dropped or changed while stalled", p);

    r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_o[p] && !r_ready_i[p] |=>
        r_valid_o[p] && $stable(r_data_o[p]) && $stable(r_resp_o[p]))
      else $error("port %0d r response dropped or changed while stalled", p);
  end

endmodule

bind axi_lite_mbox mbox_checker mbox_checker_i (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .aw_ready_o (aw_ready_o),
  .w_ready_o  (w_ready_o),
  .b_valid_o  (b_valid_o),
  .b_resp_o   (b_resp_o),
  .b_ready_i  (b_ready_i),
  .r_valid_o  (r_valid_o),
  .r_data_o   (r_data_o),
  .r_resp_o   (r_resp_o),
  .r_ready_i  (r_ready_i),
  .irq_o      (irq_o)
);

// ==== testbench/tb_axi_lite_mbox.sv ====
// Trace driven testbench for the two-port mailbox, with depth 4 and bases 1000h and 2000h.
// The trace is read from testbench/mbox_trace.txt, so run from the project root.
// One transaction at a time on one port. Responses are stalled 0 to 3 cycles at random.

module tb_axi_lite_mbox;

  localparam int unsigned Depth     = 4;
  localparam string       TraceFile = "testbench/mbox_trace.txt";

  typedef struct packed {
    logic [7:0]      op;     // w, r or i
    logic            port;
    mbox_pkg::addr_t addr;
    mbox_pkg::data_t wdata;
    logic [1:0]      resp;
    mbox_pkg::data_t data;   // read data, or irq level in bit 0
  } trace_line_t;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic            [1:0] aw_valid_i;
  mbox_pkg::addr_t [1:0] aw_addr_i;
  logic            [1:0] aw_ready_o;
  logic            [1:0] w_valid_i;
  mbox_pkg::data_t [1:0] w_data_i;
  logic            [1:0] w_ready_o;
  logic            [1:0] b_valid_o;
  mbox_pkg::resp_e [1:0] b_resp_o;
  logic            [1:0] b_ready_i;
  logic            [1:0] ar_valid_i;
  mbox_pkg::addr_t [1:0] ar_addr_i;
  logic            [1:0] ar_ready_o;
  logic            [1:0] r_valid_o;
  mbox_pkg::data_t [1:0] r_data_o;
  mbox_pkg::resp_e [1:0] r_resp_o;
  logic            [1:0] r_ready_i;
  logic            [1:0] irq_o;

  trace_line_t lines[$];
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;        // 0 until the trace is loaded
  logic [31:0] lfsr_state  = 32'h4245_af7d;

  always #10 clk_i = ~clk_i;           // period 20

  axi_lite_mbox #(
    .MailboxDepth (Depth),
    .Port0Base    (16'h1000),
    .Port1Base    (16'h2000)
  ) axi_lite_mbox_i (.*);

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_stall(output int unsigned cycles);
    cycles = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_step(lfsr_state);      // one step per bit
      cycles = {cycles[30:0], lfsr_state[0]};
    end
  endtask

  // --------------------
  // bus driver
  // --------------------
  task automatic write_word(input int unsigned port, input mbox_pkg::addr_t addr,
                            input mbox_pkg::data_t data, output mbox_pkg::resp_e resp);
    int unsigned stall;
    @(posedge clk_i);
    aw_valid_i[port] <= 1'b1;
    aw_addr_i[port]  <= addr;
    w_valid_i[port]  <= 1'b1;
    w_data_i[port]   <= data;
    @(negedge clk_i);
    while (!aw_ready_o[port]) @(negedge clk_i);
    @(posedge clk_i);                          // handshake edge
    aw_valid_i[port] <= 1'b0;
    w_valid_i[port]  <= 1'b0;
    @(negedge clk_i);
    while (!b_valid_o[port]) @(negedge clk_i);
    pick_stall(stall);
    repeat (stall) @(negedge clk_i);
    @(posedge clk_i);
    b_ready_i[port] <= 1'b1;
    @(negedge clk_i);
    resp = b_resp_o[port];                     // stable mid cycle
    @(posedge clk_i);                          // response taken
    b_ready_i[port] <= 1'b0;
  endtask

  task automatic read_word(input int unsigned port, input mbox_pkg::addr_t addr,
                           output mbox_pkg::resp_e resp, output mbox_pkg::data_t data);
    int unsigned stall;
    @(posedge clk_i);
    ar_valid_i[port] <= 1'b1;
    ar_addr_i[port]  <= addr;
    @(negedge clk_i);
    while (!ar_ready_o[port]) @(negedge clk_i);
    @(posedge clk_i);
    ar_valid_i[port] <= 1'b0;
    @(negedge clk_i);
    while (!r_valid_o[port]) @(negedge clk_i);
    pick_stall(stall);
    repeat (stall) @(negedge clk_i);
    @(posedge clk_i);
    r_ready_i[port] <= 1'b1;
    @(negedge clk_i);
    resp = r_resp_o[port];
    data = r_data_o[port];
    @(posedge clk_i);
    r_ready_i[port] <= 1'b0;
  endtask

  // irq_o sampled two cycles after the last response
  task automatic sample_irq(input int unsigned port, output logic level);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    level = irq_o[port];
  endtask

  // --------------------
  // trace
  // --------------------
  task automatic read_trace();
    int              fd;
    int              n;
    logic [8*16-1:0] tok;
    logic [8*256-1:0] rest;
    int unsigned     port;
    int unsigned     resp;
    mbox_pkg::addr_t addr;
    mbox_pkg::data_t wdata, data;
    fd = $fopen(TraceFile, "r");
    if (fd == 0) begin
      stop_with_failure("could not open the trace file testbench/mbox_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) break;
        if (tok == "#") begin
          n = $fgets(rest, fd);                 // comment line
        end else begin
          n = $fscanf(fd, "%d %h %h %d %h", port, addr, wdata, resp, data);
          if (n != 5 || !(tok == "w" || tok == "r" || tok == "i")) begin
            stop_with_failure("a line of the trace file could not be understood");
          end else begin
            lines.push_back('{tok[7:0], port[0], addr, wdata, resp[1:0], data});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input int unsigned k, input trace_line_t t);
    mbox_pkg::resp_e resp;
    mbox_pkg::data_t data;
    logic            level;
    case (t.op)
      "w": begin
        write_word(t.port, t.addr, t.wdata, resp);
        assert (resp == t.resp) else
          stop_with_failure($sformatf("ERROR at %0t: line %0d write %h to %h resp %0d, expected %0d",
                                      $time, k, t.wdata, t.addr, resp, t.resp));
      end
      "r": begin
        read_word(t.port, t.addr, resp, data);
        assert (resp == t.resp && data == t.data) else
          stop_with_failure($sformatf("ERROR at %0t: line %0d read %h got %0d/%h, expected %0d/%h",
                                      $time, k, t.addr, resp, data, t.resp, t.data));
      end
      default: begin
        sample_irq(t.port, level);
        assert (level == t.data[0]) else
          stop_with_failure($sformatf("ERROR at %0t: line %0d irq_o[%0d] is %b, expected %b",
                                      $time, k, t.port, level, t.data[0]));
      end
    endcase
  endtask

  // --------------------
  // run
  // --------------------
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      stop_with_failure($sformatf("timeout: the trace did not finish within %0d cycles",
                                  cycle_limit));
    end
  end

  initial begin
    rst_n_i    = 1'b0;
    aw_valid_i = '0;
    aw_addr_i  = '0;
    w_valid_i  = '0;
    w_data_i   = '0;
    b_ready_i  = '0;
    ar_valid_i = '0;
    ar_addr_i  = '0;
    r_ready_i  = '0;
    read_trace();
    cycle_limit = 40 * lines.size() + 100;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    for (int k = 0; k < lines.size(); k++) begin
      run_line(k, lines[k]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== testbench/mbox_trace.txt ====
# op port addr wdata resp data, all hex except port and resp (0 OKAY, 2 SLVERR)
# op w write, r read, i irq check where data holds the expected irq level
w 0 1000 11111111 0 0
w 0 1000 22222222 0 0
w 0 1000 33333333 0 0
r 1 2004 0 0 11111111
r 1 2004 0 0 22222222
r 1 2004 0 0 33333333
r 0 1000 0 0 FEEDC0DE
r 1 2004 0 2 FEEDDEAD
r 1 200C 0 0 1
r 1 200C 0 0 0
w 0 1000 A0000001 0 0
w 0 1000 A0000002 0 0
w 0 1000 A0000003 0 0
w 0 1000 A0000004 0 0
w 0 1000 A0000005 2 0
r 0 100C 0 0 2
w 0 1010 9 0 0
r 0 1010 0 0 3
r 0 1008 0 0 7
r 1 2008 0 0 8
w 0 1024 1 0 0
r 1 2008 0 0 1
r 1 2004 0 2 FEEDDEAD
w 0 1018 7 0 0
w 0 101C 4 0 0
w 0 1010 1 0 0
w 0 1000 B0000001 0 0
w 0 1000 B0000002 0 0
i 0 0 0 0 0
r 0 1004 0 2 FEEDDEAD
i 0 0 0 0 1
w 0 1018 4 0 0
i 0 0 0 0 0
r 0 1028 0 2 0
r 0 1002 0 2 0
r 1 1FFC 0 2 0
r 0 1024 0 0 0
w 1 2030 12345678 2 0
w 1 2006 12345678 2 0

// ==== verilog.f ====
design/mbox_pkg.sv
design/mbox_fifo_if.sv
design/mbox_fifo.sv
design/mbox_reg_decode.sv
design/mbox_resp_reg.sv
design/mbox_port_ctrl.sv
design/axi_lite_mbox.sv
testbench/mbox_checker.sv
testbench/tb_axi_lite_mbox.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mailbox testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_lite_mbox -f verilog.f

result=$(./obj_dir/Vtb_axi_lite_mbox) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
